// File: verilog/merge_pkg.sv
`default_nettype none

package merge_pkg;

   // APB byte address width seen by the register block
   localparam int APB_ADDR_W = 8;

   // Control register, bit 0 written as one requests a start
   localparam logic [APB_ADDR_W-1:0] REG_CTRL = 8'h00;

   // Number of idle cycles between start and the first lane
   localparam logic [APB_ADDR_W-1:0] REG_DELAY0 = 8'h04;

   // Each lane is held for stride plus one cycles
   localparam logic [APB_ADDR_W-1:0] REG_STRIDE = 8'h08;

   // Read only, bit 0 busy and bit 1 sticky done
   localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h0C;

   localparam int STATUS_BUSY_BIT = 0;
   localparam int STATUS_DONE_BIT = 1;

   // Lane i lives at REG_LANE_BASE + 4*i
   localparam logic [APB_ADDR_W-1:0] REG_LANE_BASE = 8'h40;

   // Merge engine states
   typedef enum logic [1:0] {
      IDLE,   // Waiting for a start pulse
      DELAY,  // Counting down the initial delay
      SWEEP   // Emitting lanes in ascending order
   } merge_state_t;

endpackage

`default_nettype wire

// File: verilog/merge_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface merge_ctrl_if #(
   parameter int DELAY_W = 7
) ();

   logic               start;   // One cycle launch pulse
   logic [DELAY_W-1:0] delay0;
   logic [DELAY_W-1:0] stride;
   logic               busy;
   logic               last;    // High on the final valid beat of a sweep

   modport regs_mp (
      output start,
      output delay0,
      output stride,
      input  busy,
      input  last
   );

   modport engine_mp (
      input  start,
      input  delay0,
      input  stride,
      output busy,
      output last
   );

endinterface

`default_nettype wire

// File: verilog/merge_regs.sv
`timescale 1ns/1ns
`default_nettype none

module merge_regs import merge_pkg::*; #(
   parameter int DATA_W  = 32,
   parameter int LANES   = 16,
   parameter int DELAY_W = 7,
   localparam int LANE_W = $clog2(LANES)
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   psel,
   input  wire                   penable,
   input  wire                   pwrite,
   input  wire  [APB_ADDR_W-1:0] paddr,
   input  wire  [DATA_W-1:0]     pwdata,
   output logic [DATA_W-1:0]     prdata,
   output logic                  pready,
   output logic                  pslverr,
   merge_ctrl_if.regs_mp         ctrl,
   output logic                  wr_en,
   output logic [LANE_W-1:0]     wr_addr,
   output logic [DATA_W-1:0]     wr_data,
   output logic [LANE_W-1:0]     rd_addr_host,
   input  wire  [DATA_W-1:0]     rd_data_host
);

   logic                  access;
   logic [APB_ADDR_W-1:0] lane_off;
   logic [LANE_W-1:0]     lane_idx;
   logic                  is_ctrl;
   logic                  is_delay;
   logic                  is_stride;
   logic                  is_status;
   logic                  is_lane;
   logic                  unmapped;
   logic                  busy_any;
   logic                  refused;
   logic                  wr_ok;
   logic                  start_req;
   logic [DELAY_W-1:0]    delay0_q;
   logic [DELAY_W-1:0]    stride_q;
   logic                  start_q;
   logic                  done_q;

   assign access   = psel & penable;   // APB access phase
   assign lane_off = paddr - REG_LANE_BASE;
   assign lane_idx = lane_off[LANE_W+1:2];

   assign is_ctrl   = (paddr == REG_CTRL);
   assign is_delay  = (paddr == REG_DELAY0);
   assign is_stride = (paddr == REG_STRIDE);
   assign is_status = (paddr == REG_STATUS);
   assign is_lane   = (paddr >= REG_LANE_BASE) && (lane_off[1:0] == 2'b00) &&
                      ((lane_off >> 2) < LANES);
   assign unmapped  = !(is_ctrl || is_delay || is_stride || is_status || is_lane);

   // A start still in flight counts as busy so no second one slips through
   assign busy_any = ctrl.busy | start_q;

   assign refused = pwrite & busy_any &
                    (is_delay | is_stride | is_lane | (is_ctrl & pwdata[0]));

   assign wr_ok     = access & pwrite & ~refused;
   assign start_req = wr_ok & is_ctrl & pwdata[0];

   assign pready  = 1'b1;   // Zero wait states
   assign pslverr = access & (unmapped | refused);

   assign wr_en        = wr_ok & is_lane;
   assign wr_addr      = lane_idx;
   assign wr_data      = pwdata;
   assign rd_addr_host = lane_idx;

   assign ctrl.start  = start_q;
   assign ctrl.delay0 = delay0_q;
   assign ctrl.stride = stride_q;

   always_comb begin
      prdata = '0;
      if (is_delay) begin
         prdata[DELAY_W-1:0] = delay0_q;
      end else if (is_stride) begin
         prdata[DELAY_W-1:0] = stride_q;
      end else if (is_status) begin
         prdata[STATUS_BUSY_BIT] = ctrl.busy;
         prdata[STATUS_DONE_BIT] = done_q;
      end else if (is_lane) begin
         prdata = rd_data_host;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         delay0_q <= '0;
         stride_q <= '0;
         start_q  <= 1'b0;
         done_q   <= 1'b0;
      end else begin
         start_q <= start_req;
         if (wr_ok && is_delay) begin
            delay0_q <= pwdata[DELAY_W-1:0];
         end
         if (wr_ok && is_stride) begin
            stride_q <= pwdata[DELAY_W-1:0];
         end
         if (start_req) begin
            done_q <= 1'b0;
         end else if (ctrl.last) begin
            done_q <= 1'b1;   // Sticky until the next start
         end
      end
   end

   // The engine must be idle when it sees start, and it must pick the start up
   a_start_when_idle: assert property (@(posedge clk) disable iff (rst)
      ctrl.start |-> (!ctrl.busy ##1 ctrl.busy));

endmodule

`default_nettype wire

// File: verilog/lane_bank.sv
`timescale 1ns/1ns
`default_nettype none

module lane_bank #(
   parameter int DATA_W = 32,
   parameter int LANES  = 16,
   localparam int LANE_W = $clog2(LANES)
) (
   input  wire                clk,
   input  wire                rst,
   input  wire                wr_en,
   input  wire  [LANE_W-1:0]  wr_addr,
   input  wire  [DATA_W-1:0]  wr_data,
   input  wire  [LANE_W-1:0]  rd_addr_host,
   output logic [DATA_W-1:0]  rd_data_host,
   input  wire  [LANE_W-1:0]  rd_addr_eng,
   output logic [DATA_W-1:0]  rd_data_eng
);

   logic [DATA_W-1:0] lanes [LANES];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < LANES; i++) begin
            lanes[i] <= '0;
         end
      end else if (wr_en) begin
         lanes[wr_addr] <= wr_data;
      end
   end

   // Both read ports are plain muxes on the array
   assign rd_data_host = lanes[rd_addr_host];
   assign rd_data_eng  = lanes[rd_addr_eng];

endmodule

`default_nettype wire

// File: verilog/strided_merge.sv
`timescale 1ns/1ns
`default_nettype none

module strided_merge import merge_pkg::*; #(
   parameter int DATA_W  = 32,
   parameter int LANES   = 16,
   parameter int DELAY_W = 7,
   localparam int LANE_W = $clog2(LANES)
) (
   input  wire                clk,
   input  wire                rst,
   merge_ctrl_if.engine_mp    ctrl,
   output logic [LANE_W-1:0]  rd_addr_eng,
   input  wire  [DATA_W-1:0]  rd_data_eng,
   output logic               out_valid,
   output logic [DATA_W-1:0]  out_data,
   output logic [LANE_W-1:0]  out_lane
);

   merge_state_t       state;
   merge_state_t       state_nxt;
   logic [DELAY_W-1:0] delay_cnt;
   logic [DELAY_W-1:0] delay_nxt;
   logic [DELAY_W-1:0] stride_cnt;
   logic [DELAY_W-1:0] stride_nxt;
   logic [DELAY_W-1:0] stride_q;
   logic [LANE_W-1:0]  lane;
   logic [LANE_W-1:0]  lane_nxt;
   logic               hold_end;

   assign hold_end  = (stride_cnt == stride_q);   // Current lane has had its stride+1 cycles
   assign ctrl.last = (state == SWEEP) && hold_end && (lane == LANE_W'(LANES - 1));
   assign ctrl.busy = (state != IDLE);

   always_comb begin
      state_nxt  = state;
      delay_nxt  = delay_cnt;
      stride_nxt = stride_cnt;
      lane_nxt   = lane;
      case (state)
         IDLE: begin
            if (ctrl.start) begin
               delay_nxt  = ctrl.delay0;
               stride_nxt = '0;
               lane_nxt   = '0;
               state_nxt  = (ctrl.delay0 == '0) ? SWEEP : DELAY;
            end
         end
         DELAY: begin
            delay_nxt = delay_cnt - 1'b1;
            if (delay_cnt == DELAY_W'(1)) begin
               state_nxt = SWEEP;
            end
         end
         SWEEP: begin
            if (!hold_end) begin
               stride_nxt = stride_cnt + 1'b1;
            end else begin
               stride_nxt = '0;
               if (ctrl.last) begin
                  state_nxt = IDLE;
               end else begin
                  lane_nxt = lane + 1'b1;
               end
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   // Look ahead by one lane so the word lands in out_data together with its index
   assign rd_addr_eng = lane_nxt;
   assign out_lane    = lane;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= IDLE;
         delay_cnt  <= '0;
         stride_cnt <= '0;
         stride_q   <= '0;
         lane       <= '0;
         out_valid  <= 1'b0;
      end else begin
         state      <= state_nxt;
         delay_cnt  <= delay_nxt;
         stride_cnt <= stride_nxt;
         lane       <= lane_nxt;
         out_valid  <= (state_nxt == SWEEP);
         if (state == IDLE && ctrl.start) begin
            stride_q <= ctrl.stride;   // Held for the whole sweep
         end
      end
   end

   always_ff @(posedge clk) begin
      out_data <= rd_data_eng;
   end

   a_lane_range: assert property (@(posedge clk) disable iff (rst)
      lane <= LANE_W'(LANES - 1));

   a_valid_in_sweep: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> (state == SWEEP));

   // The sweep ends in SWEEP and busy drops on the following cycle
   a_last_in_sweep: assert property (@(posedge clk) disable iff (rst)
      ctrl.last |-> ((state == SWEEP) ##1 !ctrl.busy));

endmodule

`default_nettype wire

// File: verilog/merge_top.sv
`timescale 1ns/1ns
`default_nettype none

module merge_top import merge_pkg::*; #(
   parameter int DATA_W  = 32,
   parameter int LANES   = 16,
   parameter int DELAY_W = 7,
   localparam int LANE_W = $clog2(LANES)
) (
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   psel,
   input  wire                   penable,
   input  wire                   pwrite,
   input  wire  [APB_ADDR_W-1:0] paddr,
   input  wire  [DATA_W-1:0]     pwdata,
   output logic [DATA_W-1:0]     prdata,
   output logic                  pready,
   output logic                  pslverr,
   output logic                  out_valid,
   output logic [DATA_W-1:0]     out_data,
   output logic [LANE_W-1:0]     out_lane
);

   logic              wr_en;
   logic [LANE_W-1:0] wr_addr;
   logic [DATA_W-1:0] wr_data;
   logic [LANE_W-1:0] rd_addr_host;
   logic [DATA_W-1:0] rd_data_host;
   logic [LANE_W-1:0] rd_addr_eng;
   logic [DATA_W-1:0] rd_data_eng;

   merge_ctrl_if #(.DELAY_W(DELAY_W)) ctrl_if ();

   merge_regs #(
      .DATA_W  (DATA_W),
      .LANES   (LANES),
      .DELAY_W (DELAY_W)
   ) i_regs (
      .clk          (clk),
      .rst          (rst),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .pslverr      (pslverr),
      .ctrl         (ctrl_if.regs_mp),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .rd_addr_host (rd_addr_host),
      .rd_data_host (rd_data_host)
   );

   lane_bank #(
      .DATA_W (DATA_W),
      .LANES  (LANES)
   ) i_bank (
      .clk          (clk),
      .rst          (rst),
      .wr_en        (wr_en),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .rd_addr_host (rd_addr_host),
      .rd_data_host (rd_data_host),
      .rd_addr_eng  (rd_addr_eng),
      .rd_data_eng  (rd_data_eng)
   );

   strided_merge #(
      .DATA_W  (DATA_W),
      .LANES   (LANES),
      .DELAY_W (DELAY_W)
   ) i_engine (
      .clk         (clk),
      .rst         (rst),
      .ctrl        (ctrl_if.engine_mp),
      .rd_addr_eng (rd_addr_eng),
      .rd_data_eng (rd_data_eng),
      .out_valid   (out_valid),
      .out_data    (out_data),
      .out_lane    (out_lane)
   );

endmodule

`default_nettype wire

// File: bench/tb_merge_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_merge_top import merge_pkg::*; ();

   localparam int DATA_W     = 32;
   localparam int LANES      = 16;
   localparam int DELAY_W    = 7;
   localparam int LANE_W     = $clog2(LANES);
   localparam int HALF       = 10;
   localparam int POLL_LIMIT = 400;   // Status polls before giving up on done

   logic                  clk;
   logic                  rst;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [APB_ADDR_W-1:0] paddr;
   logic [DATA_W-1:0]     pwdata;
   logic [DATA_W-1:0]     prdata;
   logic                  pready;
   logic                  pslverr;
   logic                  out_valid;
   logic [DATA_W-1:0]     out_data;
   logic [LANE_W-1:0]     out_lane;

   int                cycle_cnt;
   int                access_cycle;
   int                start_cycle;
   int                errors;
   int                tests_run;
   int                tests_failed;
   logic [DATA_W-1:0] lane_model [LANES];
   int                beat_lane [$];
   logic [DATA_W-1:0] beat_data [$];
   int                beat_cycle [$];

   merge_top #(.DATA_W(DATA_W), .LANES(LANES), .DELAY_W(DELAY_W)) i_dut (
      .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .out_valid(out_valid), .out_data(out_data), .out_lane(out_lane)
   );

   always #(HALF) clk = ~clk;

   // Stream outputs are registered, so the falling edge sees them settled
   always @(negedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (!rst && out_valid) begin
         beat_lane.push_back(int'(out_lane));
         beat_data.push_back(out_data);
         beat_cycle.push_back(cycle_cnt);
      end
   end

   function automatic logic [APB_ADDR_W-1:0] lane_addr(input int i);
      return REG_LANE_BASE + APB_ADDR_W'(4 * i);
   endfunction

   task automatic expect_eq(input string what, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // Setup cycle, then the access cycle sampled halfway to the rising edge
   task automatic apb_transfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #(HALF / 2);
      rdata        = prdata;
      err          = pslverr;
      access_cycle = cycle_cnt;
      expect_eq("pready", pready, 1);   // Zero wait states, so the access completes here
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            output logic err);
      logic [DATA_W-1:0] unused_rd;
      apb_transfer(1'b1, addr, data, unused_rd, err);
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic err);
      apb_transfer(1'b0, addr, '0, data, err);
   endtask

   task automatic wait_done();
      logic [DATA_W-1:0] st;
      logic              e;
      int                polls;
      polls = 0;
      st    = '0;
      while (!st[STATUS_DONE_BIT] && polls < POLL_LIMIT) begin
         apb_read(REG_STATUS, st, e);
         polls++;
      end
      if (!st[STATUS_DONE_BIT]) begin
         $display("Timeout at %0t: done bit still clear after %0d polls", $time, polls);
         errors++;
      end
   endtask

   task automatic load_lanes();
      logic e;
      for (int i = 0; i < LANES; i++) begin
         lane_model[i] = $urandom;
         apb_write(lane_addr(i), lane_model[i], e);
         expect_eq($sformatf("pslverr on lane %0d write", i), e, 0);
      end
   endtask

   task automatic start_sweep(input int delay0, input int stride);
      logic e;
      apb_write(REG_DELAY0, DATA_W'(delay0), e);
      expect_eq("pslverr on DELAY0 write", e, 0);
      apb_write(REG_STRIDE, DATA_W'(stride), e);
      expect_eq("pslverr on STRIDE write", e, 0);
      beat_lane.delete();
      beat_data.delete();
      beat_cycle.delete();
      apb_write(REG_CTRL, 32'h1, e);
      expect_eq("pslverr on start", e, 0);
      start_cycle = access_cycle;
   endtask

   // Start lands one cycle after the access, then delay0 idle cycles, then hold lanes
   task automatic check_sweep(input int delay0, input int stride);
      int hold;
      int lane;
      hold = stride + 1;
      if (beat_lane.size() != LANES * hold) begin
         $display("Mismatch at %0t: beat count is %0d, expected %0d", $time,
                  beat_lane.size(), LANES * hold);
         errors++;
      end
      for (int i = 0; i < beat_lane.size() && i < LANES * hold; i++) begin
         lane = i / hold;
         expect_eq($sformatf("out_lane of beat %0d", i), beat_lane[i], lane);
         expect_eq($sformatf("out_data of beat %0d", i), beat_data[i], lane_model[lane]);
         expect_eq($sformatf("cycle of beat %0d", i), beat_cycle[i], start_cycle + 2 + delay0 + i);
      end
   endtask

   task automatic report_test(input string name, input int err0);
      tests_run++;
      if (errors != err0) begin
         tests_failed++;
         $display("Test %s: fail, %0d errors", name, errors - err0);
      end else begin
         $display("Test %s: pass", name);
      end
   endtask

   task automatic reset_and_registers();
      int                err0;
      logic [DATA_W-1:0] d;
      logic              e;
      err0 = errors;
      apb_read(REG_STATUS, d, e);
      expect_eq("STATUS after reset", d, 0);
      apb_read(REG_STRIDE, d, e);
      expect_eq("STRIDE after reset", d, 0);
      apb_read(lane_addr(5), d, e);
      expect_eq("lane 5 after reset", d, 0);
      apb_write(REG_DELAY0, 32'd7, e);
      apb_read(REG_DELAY0, d, e);
      expect_eq("DELAY0 readback", d, 7);
      apb_write(REG_STRIDE, 32'd3, e);
      apb_read(REG_STRIDE, d, e);
      expect_eq("STRIDE readback", d, 3);
      load_lanes();
      for (int i = 0; i < LANES; i += 5) begin
         apb_read(lane_addr(i), d, e);
         expect_eq($sformatf("lane %0d readback", i), d, lane_model[i]);
         expect_eq("pslverr on lane read", e, 0);
      end
      apb_read(8'h10, d, e);
      expect_eq("pslverr at 0x10", e, 1);
      apb_read(8'h42, d, e);   // Not word aligned
      expect_eq("pslverr at 0x42", e, 1);
      apb_write(8'h80, 32'h1234, e);
      expect_eq("pslverr at 0x80", e, 1);
      report_test("reset and registers", err0);
   endtask

   task automatic plain_sweep();
      int err0;
      err0 = errors;
      load_lanes();
      start_sweep(0, 0);
      wait_done();
      check_sweep(0, 0);
      report_test("plain sweep", err0);
   endtask

   task automatic strided_sweep();
      int err0;
      err0 = errors;
      load_lanes();
      start_sweep(5, 3);
      if (beat_lane.size() != 0) begin
         $display("Error at %0t: stream beat seen before the sweep could start", $time);
         errors++;
      end
      wait_done();
      check_sweep(5, 3);
      report_test("strided sweep", err0);
   endtask

   task automatic busy_protection();
      int                err0;
      logic [DATA_W-1:0] d;
      logic              e;
      err0 = errors;
      start_sweep(40, 10);
      apb_read(REG_STATUS, d, e);
      expect_eq("STATUS busy bit", d[STATUS_BUSY_BIT], 1);
      apb_write(lane_addr(3), ~lane_model[3], e);
      expect_eq("pslverr on lane write while busy", e, 1);
      apb_write(REG_STRIDE, 32'd1, e);
      expect_eq("pslverr on STRIDE write while busy", e, 1);
      apb_write(REG_CTRL, 32'h1, e);
      expect_eq("pslverr on start while busy", e, 1);
      wait_done();
      check_sweep(40, 10);
      for (int i = 0; i < LANES; i++) begin
         apb_read(lane_addr(i), d, e);
         expect_eq($sformatf("lane %0d after refused write", i), d, lane_model[i]);
      end
      apb_read(REG_STRIDE, d, e);
      expect_eq("STRIDE after refused write", d, 10);
      report_test("busy protection", err0);
   endtask

   task automatic completion_restart();
      int                err0;
      logic [DATA_W-1:0] d;
      logic              e;
      err0 = errors;
      apb_read(REG_STATUS, d, e);
      expect_eq("STATUS after sweep", d, 32'h2);   // Done set, busy clear
      start_sweep(1, 2);
      apb_read(REG_STATUS, d, e);
      expect_eq("STATUS after restart", d, 32'h1);
      wait_done();
      check_sweep(1, 2);
      apb_read(REG_STATUS, d, e);
      expect_eq("STATUS after second sweep", d, 32'h2);
      report_test("completion and restart", err0);
   endtask

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      cycle_cnt    = 0;
      access_cycle = 0;
      start_cycle  = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      void'($urandom(81278));
      repeat (5) @(negedge clk);
      rst = 1'b0;
      reset_and_registers();
      plain_sweep();
      strided_sweep();
      busy_protection();
      completion_restart();
      $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
verilog/merge_pkg.sv
verilog/merge_ctrl_if.sv
verilog/merge_regs.sv
verilog/lane_bank.sv
verilog/strided_merge.sv
verilog/merge_top.sv
bench/tb_merge_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_merge_top \
   -f src.f -o sim_merge \
   && ./obj_dir/sim_merge | tee sim.log \
   && grep -q "TESTS PASSED" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
